//--- hdl/game_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "shooter_config.svh"

module game_ctrl (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire shooter_pkg::coord_t x_i,
    input  wire shooter_pkg::coord_t y_i,
    input  wire logic [4:0]          key_i,
    input  wire logic                hit_i,
    input  wire logic                miss_i,
    output logic                     frame_tick_o,
    output logic                     run_o,
    output shooter_pkg::score_t      score_o,
    output logic [1:0]               lives_o,
    output logic                     game_over_o
);

    localparam shooter_pkg::coord_t LAST_X     = shooter_pkg::coord_t'(`SCREEN_W - 1);
    localparam shooter_pkg::coord_t LAST_Y     = shooter_pkg::coord_t'(`SCREEN_H - 1);
    localparam logic [1:0]          FULL_LIVES = 2'(`START_LIVES);

    shooter_pkg::game_state_e state_q;
    shooter_pkg::game_state_e state_d;
    logic [1:0]               lives_q;
    logic [1:0]               lives_d;
    shooter_pkg::score_t      score_q;
    shooter_pkg::score_t      score_d;
    shooter_pkg::score_t      score_inc;
    logic                     over_q;
    logic                     start;

    assign frame_tick_o = (x_i == LAST_X) && (y_i == LAST_Y); // last pixel of the frame
    assign start        = key_i[4];

    // two digit bcd, 99 rolls to 00
    always_comb begin
        score_inc = score_q;
        if (score_q.ones == 4'd9) begin
            score_inc.ones = 4'd0;
            score_inc.tens = (score_q.tens == 4'd9) ? 4'd0 : score_q.tens + 4'd1;
        end else begin
            score_inc.ones = score_q.ones + 4'd1;
        end
    end

    always_comb begin
        state_d = state_q;
        lives_d = lives_q;
        score_d = score_q;
        case (state_q)
            shooter_pkg::NEWGAME: begin
                if (start) begin
                    state_d = shooter_pkg::PLAY;
                    lives_d = FULL_LIVES;
                    score_d = '0; // fresh game
                end
            end
            shooter_pkg::PLAY: begin
                if (hit_i) begin
                    score_d = score_inc;
                end
                if (miss_i) begin
                    lives_d = lives_q - 2'd1;
                    if (lives_q == 2'd1) begin
                        state_d = shooter_pkg::OVER; // last life gone
                    end else begin
                        state_d = shooter_pkg::NEWGUN;
                    end
                end
            end
            shooter_pkg::NEWGUN: begin
                if (start) begin
                    state_d = shooter_pkg::PLAY;
                end
            end
            shooter_pkg::OVER: begin
                if (start) begin
                    state_d = shooter_pkg::NEWGAME;
                end
            end
            default: state_d = shooter_pkg::NEWGAME;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= shooter_pkg::NEWGAME;
            lives_q <= FULL_LIVES;
            score_q <= '0;
            over_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            lives_q <= lives_d;
            score_q <= score_d;
            over_q  <= (state_d == shooter_pkg::OVER);
        end
    end

    assign run_o       = (state_q == shooter_pkg::PLAY); // objects move only here
    assign score_o     = score_q;
    assign lives_o     = lives_q;
    assign game_over_o = over_q;

endmodule

`default_nettype wire

//--- hdl/gun_shot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "shooter_config.svh"

module gun_shot_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   frame_tick_i,
    input  wire logic                   run_i,
    input  wire shooter_pkg::key_code_e key_i,
    input  wire logic                   hit_i,
    output shooter_pkg::pos_t           gun_pos_o,
    output shooter_pkg::pos_t           shot_pos_o
);

    localparam shooter_pkg::coord_t GUN_X0    = shooter_pkg::coord_t'((`SCREEN_W - `GUN_W) / 2);
    localparam shooter_pkg::coord_t GUN_X_MAX = shooter_pkg::coord_t'(`SCREEN_W - `GUN_W - `GUN_V);
    localparam shooter_pkg::coord_t GUN_STEP  = shooter_pkg::coord_t'(`GUN_V);
    localparam shooter_pkg::coord_t GUN_TOP   = shooter_pkg::coord_t'(`GUN_Y_T);
    localparam shooter_pkg::coord_t MUZZLE_DX = shooter_pkg::coord_t'(`GUN_W / 2);
    localparam shooter_pkg::coord_t MUZZLE_Y  = shooter_pkg::coord_t'((`GUN_Y_T + `GUN_Y_B) / 2);
    localparam shooter_pkg::coord_t SHOT_STEP = shooter_pkg::coord_t'(`SHOT_V);

    shooter_pkg::coord_t gun_x_q;
    shooter_pkg::pos_t   shot_q;
    shooter_pkg::pos_t   muzzle;
    logic                shot_home;

    assign muzzle = '{x: gun_x_q + MUZZLE_DX, y: MUZZLE_Y}; // from gun before the tick

    // shot goes back on a hit, on release, or near the top edge
    assign shot_home = hit_i || (key_i != shooter_pkg::KEY_FIRE) || (shot_q.y < SHOT_STEP);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gun_x_q <= GUN_X0;
        end else if (!run_i) begin
            gun_x_q <= GUN_X0; // park in the middle
        end else if (frame_tick_i) begin
            if (key_i == shooter_pkg::KEY_RIGHT && gun_x_q <= GUN_X_MAX) begin
                gun_x_q <= gun_x_q + GUN_STEP;
            end else if (key_i == shooter_pkg::KEY_LEFT && gun_x_q >= GUN_STEP) begin
                gun_x_q <= gun_x_q - GUN_STEP;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shot_q <= '{x: GUN_X0 + MUZZLE_DX, y: MUZZLE_Y};
        end else if (!run_i) begin
            shot_q <= '{x: GUN_X0 + MUZZLE_DX, y: MUZZLE_Y};
        end else if (frame_tick_i) begin
            if (shot_home) begin
                shot_q <= muzzle;
            end else begin
                shot_q.y <= shot_q.y - SHOT_STEP; // flies straight up
            end
        end
    end

    assign gun_pos_o  = '{x: gun_x_q, y: GUN_TOP};
    assign shot_pos_o = shot_q;

endmodule

`default_nettype wire

//--- hdl/obstacle_field.sv
`timescale 1ns/1ps
`default_nettype none
`include "shooter_config.svh"

module obstacle_field (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              frame_tick_i,
    input  wire logic                              run_i,
    input  wire shooter_pkg::pos_t                 shot_pos_i,
    output shooter_pkg::obs_t [`NUM_OBS-1:0]       obs_o,
    output logic                                   hit_o,
    output logic                                   miss_o
);

    localparam shooter_pkg::coord_t OBS_EXT  = shooter_pkg::coord_t'(`OBS_SIZE - 1);
    localparam shooter_pkg::coord_t SHOT_EXT = shooter_pkg::coord_t'(`SHOT_SIZE - 1);
    localparam shooter_pkg::coord_t BOTTOM   = shooter_pkg::coord_t'(`SCREEN_H - 1);
    localparam shooter_pkg::coord_t FALL     = shooter_pkg::coord_t'(`OBS_V);

    // table entry for obstacle idx
    function automatic shooter_pkg::obs_t spawn_obs(input int idx);
        shooter_pkg::obs_t o;
        o.alive = 1'b1;
        o.pos.x = shooter_pkg::coord_t'(`OBS_X0 + idx * `OBS_PITCH);
        o.pos.y = shooter_pkg::coord_t'(`OBS_Y0);
        return o;
    endfunction

    shooter_pkg::obs_t [`NUM_OBS-1:0] obs_q;
    logic [`NUM_OBS-1:0]              hit_vec;
    logic [`NUM_OBS-1:0]              miss_vec;
    logic [`NUM_OBS-1:0]              alive_vec;
    shooter_pkg::coord_t              shot_r;
    shooter_pkg::coord_t              shot_b;
    logic                             tick_run;
    logic                             respawn;

    assign shot_r   = shot_pos_i.x + SHOT_EXT;
    assign shot_b   = shot_pos_i.y + SHOT_EXT;
    assign tick_run = frame_tick_i & run_i;

    always_comb begin
        for (int i = 0; i < `NUM_OBS; i++) begin
            alive_vec[i] = obs_q[i].alive;
            // shot fully inside horizontally, any vertical overlap
            hit_vec[i] = obs_q[i].alive
                         && (shot_pos_i.x >= obs_q[i].pos.x)
                         && (shot_r <= obs_q[i].pos.x + OBS_EXT)
                         && (shot_b >= obs_q[i].pos.y)
                         && (shot_pos_i.y <= obs_q[i].pos.y + OBS_EXT);
            miss_vec[i] = obs_q[i].alive && !hit_vec[i]
                          && (obs_q[i].pos.y + OBS_EXT >= BOTTOM); // reached the floor
        end
    end

    assign hit_o   = tick_run & (|hit_vec);
    assign miss_o  = tick_run & (|miss_vec);
    assign respawn = !run_i || (frame_tick_i && !(|alive_vec)); // idle or wave cleared

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_OBS; i++) begin
                obs_q[i] <= spawn_obs(i);
            end
        end else if (respawn) begin
            for (int i = 0; i < `NUM_OBS; i++) begin
                obs_q[i] <= spawn_obs(i);
            end
        end else if (frame_tick_i) begin
            for (int i = 0; i < `NUM_OBS; i++) begin
                if (hit_vec[i] || miss_vec[i]) begin
                    obs_q[i].alive <= 1'b0; // removed, position kept
                end else if (obs_q[i].alive) begin
                    obs_q[i].pos.y <= obs_q[i].pos.y + FALL;
                end
            end
        end
    end

    assign obs_o = obs_q;

endmodule

`default_nettype wire

//--- hdl/pixel_painter.sv
`timescale 1ns/1ps
`default_nettype none
`include "shooter_config.svh"

module pixel_painter (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire shooter_pkg::coord_t         x_i,
    input  wire shooter_pkg::coord_t         y_i,
    input  wire shooter_pkg::pos_t           gun_pos_i,
    input  wire shooter_pkg::pos_t           shot_pos_i,
    input  wire shooter_pkg::obs_t [`NUM_OBS-1:0] obs_i,
    output shooter_pkg::color_e              rgb_o
);

    // pixel inside a w by h box anchored at corner
    function automatic logic in_box(input shooter_pkg::coord_t px,
                                    input shooter_pkg::coord_t py,
                                    input shooter_pkg::pos_t corner,
                                    input int w,
                                    input int h);
        return (int'(px) >= int'(corner.x)) && (int'(px) <= int'(corner.x) + w - 1)
            && (int'(py) >= int'(corner.y)) && (int'(py) <= int'(corner.y) + h - 1);
    endfunction

    logic                shot_on;
    logic                gun_on;
    logic                obs_on;
    shooter_pkg::color_e rgb_d;

    assign shot_on = in_box(x_i, y_i, shot_pos_i, `SHOT_SIZE, `SHOT_SIZE);
    assign gun_on  = in_box(x_i, y_i, gun_pos_i, `GUN_W, `GUN_Y_B - `GUN_Y_T + 1);

    always_comb begin
        obs_on = 1'b0;
        for (int i = 0; i < `NUM_OBS; i++) begin
            obs_on |= obs_i[i].alive && in_box(x_i, y_i, obs_i[i].pos, `OBS_SIZE, `OBS_SIZE);
        end
    end

    always_comb begin
        if (shot_on) begin
            rgb_d = shooter_pkg::RED; // shot on top
        end else if (gun_on) begin
            rgb_d = shooter_pkg::WHITE;
        end else if (obs_on) begin
            rgb_d = shooter_pkg::BLUE;
        end else begin
            rgb_d = shooter_pkg::BLACK;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_o <= shooter_pkg::BLACK;
        end else begin
            rgb_o <= rgb_d; // one cycle behind x_i, y_i
        end
    end

endmodule

`default_nettype wire

//--- hdl/shooter_config.svh
`ifndef SHOOTER_CONFIG_SVH
`define SHOOTER_CONFIG_SVH

// raster
`define SCREEN_W 640
`define SCREEN_H 480
`define COORD_W 10

// gun rectangle and step per frame
`define GUN_Y_T 420
`define GUN_Y_B 470
`define GUN_W 60
`define GUN_V 4

// shot square and upward speed
`define SHOT_SIZE 6
`define SHOT_V 5

// obstacle square and fall speed
`define OBS_SIZE 30
`define OBS_V 2

// spawn table, x of obstacle i is OBS_X0 + i * OBS_PITCH
`define NUM_OBS 4
`define OBS_X0 60
`define OBS_PITCH 150
`define OBS_Y0 30

`define START_LIVES 3

`endif

//--- hdl/shooter_pkg.sv
`default_nettype none
`include "shooter_config.svh"

package shooter_pkg;

    typedef logic [`COORD_W-1:0] coord_t;

    // top-left corner of a sprite
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef struct packed {
        logic alive;
        pos_t pos;
    } obs_t;

    // bit 4 of any code doubles as start
    typedef enum logic [4:0] {
        KEY_RIGHT = 5'h11,
        KEY_LEFT  = 5'h13,
        KEY_FIRE  = 5'h15
    } key_code_e;

    typedef enum logic [1:0] {
        NEWGAME = 2'd0,
        PLAY    = 2'd1,
        NEWGUN  = 2'd2,
        OVER    = 2'd3
    } game_state_e;

    typedef struct packed {
        logic [3:0] tens; // bcd
        logic [3:0] ones; // bcd
    } score_t;

    typedef enum logic [2:0] {
        BLACK = 3'b000,
        BLUE  = 3'b001,
        RED   = 3'b100,
        WHITE = 3'b111
    } color_e;

endpackage

`default_nettype wire

//--- hdl/shooter_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "shooter_config.svh"

module shooter_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire shooter_pkg::coord_t x_i,
    input  wire shooter_pkg::coord_t y_i,
    input  wire logic [4:0]          key_i,
    output shooter_pkg::color_e      rgb_o,
    output shooter_pkg::score_t      score_o,
    output logic [1:0]               lives_o,
    output logic                     game_over_o
);

    logic                             frame_tick;
    logic                             run;
    logic                             hit;
    logic                             miss;
    shooter_pkg::pos_t                gun_pos;
    shooter_pkg::pos_t                shot_pos;
    shooter_pkg::obs_t [`NUM_OBS-1:0] obs;

    game_ctrl u_game_ctrl (
        .clk          (clk),
        .rst          (rst),
        .x_i          (x_i),
        .y_i          (y_i),
        .key_i        (key_i),
        .hit_i        (hit),
        .miss_i       (miss),
        .frame_tick_o (frame_tick),
        .run_o        (run),
        .score_o      (score_o),
        .lives_o      (lives_o),
        .game_over_o  (game_over_o)
    );

    gun_shot_ctrl u_gun_shot_ctrl (
        .clk          (clk),
        .rst          (rst),
        .frame_tick_i (frame_tick),
        .run_i        (run),
        .key_i        (shooter_pkg::key_code_e'(key_i)), // raw code, 0 when idle
        .hit_i        (hit),
        .gun_pos_o    (gun_pos),
        .shot_pos_o   (shot_pos)
    );

    obstacle_field u_obstacle_field (
        .clk          (clk),
        .rst          (rst),
        .frame_tick_i (frame_tick),
        .run_i        (run),
        .shot_pos_i   (shot_pos),
        .obs_o        (obs),
        .hit_o        (hit),
        .miss_o       (miss)
    );

    pixel_painter u_pixel_painter (
        .clk          (clk),
        .rst          (rst),
        .x_i          (x_i),
        .y_i          (y_i),
        .gun_pos_i    (gun_pos),
        .shot_pos_i   (shot_pos),
        .obs_i        (obs),
        .rgb_o        (rgb_o)
    );

endmodule

`default_nettype wire

//--- shooter.f
+incdir+hdl
hdl/shooter_pkg.sv
hdl/gun_shot_ctrl.sv
hdl/obstacle_field.sv
hdl/game_ctrl.sv
hdl/pixel_painter.sv
hdl/shooter_top.sv
verification/shooter_assertions.sv
verification/shooter_checker.sv
verification/shooter_tb.sv

//--- verification/shooter_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "shooter_config.svh"

module shooter_assertions (
    input wire logic                clk,
    input wire logic                rst,
    input wire shooter_pkg::color_e rgb_i,
    input wire shooter_pkg::score_t score_i,
    input wire logic [1:0]          lives_i,
    input wire logic                game_over_i
);

    int fail_count = 0;

    rgb_is_legal: assert property (@(posedge clk) disable iff (rst)
        rgb_i inside {shooter_pkg::BLACK, shooter_pkg::BLUE, shooter_pkg::RED, shooter_pkg::WHITE})
    else begin
        fail_count++;
        $error("rgb_o carries a code outside the colour set");
    end

    score_is_bcd: assert property (@(posedge clk) disable iff (rst)
        (score_i.tens <= 4'd9) && (score_i.ones <= 4'd9))
    else begin
        fail_count++;
        $error("score_o holds a digit above 9");
    end

    over_has_no_lives: assert property (@(posedge clk) disable iff (rst)
        game_over_i |-> (lives_i == 2'd0))
    else begin
        fail_count++;
        $error("game_over_o is high while lives_o is not zero");
    end

    // lives only ever go up when a new game refills them
    lives_in_range: assert property (@(posedge clk) disable iff (rst)
        (lives_i <= 2'(`START_LIVES))
        && ((lives_i <= $past(lives_i)) || (lives_i == 2'(`START_LIVES))))
    else begin
        fail_count++;
        $error("lives_o is above the starting life count or rose to another count");
    end

endmodule

`default_nettype wire

//--- verification/shooter_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "shooter_config.svh"

module shooter_checker (
    input wire logic                clk,
    input wire logic                rst,
    input wire shooter_pkg::coord_t x_i,
    input wire shooter_pkg::coord_t y_i,
    input wire logic [4:0]          key_i,
    input wire shooter_pkg::color_e rgb_i,
    input wire shooter_pkg::score_t score_i,
    input wire logic [1:0]          lives_i,
    input wire logic                game_over_i
);

    localparam int GUN_H     = `GUN_Y_B - `GUN_Y_T + 1;
    localparam int GUN_X0    = (`SCREEN_W - `GUN_W) / 2;
    localparam int MUZZLE_DX = `GUN_W / 2;
    localparam int MUZZLE_Y  = (`GUN_Y_T + `GUN_Y_B) / 2;

    shooter_pkg::game_state_e m_state;
    shooter_pkg::color_e      exp_rgb; // colour the DUT shows after the last edge
    int                       m_lives;
    int                       m_score; // plain decimal 0..99
    int                       m_gun_x;
    int                       m_shot_x;
    int                       m_shot_y;
    int                       m_obs_x [`NUM_OBS];
    int                       m_obs_y [`NUM_OBS];
    bit                       m_alive [`NUM_OBS];
    int                       error_count = 0;
    int                       hit_count = 0;
    int                       miss_count = 0;
    int                       over_count = 0;

    function automatic bit inside_box(input int px, input int py, input int bx, input int by,
                                      input int w, input int h);
        return (px >= bx) && (px < bx + w) && (py >= by) && (py < by + h);
    endfunction

    task automatic spawn_objects();
        m_gun_x  = GUN_X0;
        m_shot_x = GUN_X0 + MUZZLE_DX; // resting at the muzzle
        m_shot_y = MUZZLE_Y;
        for (int i = 0; i < `NUM_OBS; i++) begin
            m_obs_x[i] = `OBS_X0 + i * `OBS_PITCH;
            m_obs_y[i] = `OBS_Y0;
            m_alive[i] = 1'b1;
        end
    endtask

    function automatic shooter_pkg::color_e expected_color(input int px, input int py);
        bit on_obs;
        on_obs = 1'b0;
        for (int i = 0; i < `NUM_OBS; i++) begin
            if (m_alive[i] && inside_box(px, py, m_obs_x[i], m_obs_y[i], `OBS_SIZE, `OBS_SIZE))
                on_obs = 1'b1;
        end
        if (inside_box(px, py, m_shot_x, m_shot_y, `SHOT_SIZE, `SHOT_SIZE))
            return shooter_pkg::RED;
        if (inside_box(px, py, m_gun_x, `GUN_Y_T, `GUN_W, GUN_H))
            return shooter_pkg::WHITE;
        if (on_obs)
            return shooter_pkg::BLUE;
        return shooter_pkg::BLACK;
    endfunction

    // one clock edge of the game
    task automatic advance_model(input int px, input int py, input logic [4:0] key);
        bit tick;
        bit run;
        bit hit;
        bit miss;
        bit any_alive;
        bit hit_obs [`NUM_OBS];
        bit miss_obs [`NUM_OBS];
        int old_gun_x;
        tick      = (px == `SCREEN_W - 1) && (py == `SCREEN_H - 1);
        run       = (m_state == shooter_pkg::PLAY);
        hit       = 1'b0;
        miss      = 1'b0;
        any_alive = 1'b0;
        for (int i = 0; i < `NUM_OBS; i++) begin
            hit_obs[i] = m_alive[i] && (m_shot_x >= m_obs_x[i])
                         && (m_shot_x + `SHOT_SIZE <= m_obs_x[i] + `OBS_SIZE)
                         && (m_shot_y + `SHOT_SIZE > m_obs_y[i])
                         && (m_shot_y < m_obs_y[i] + `OBS_SIZE);
            miss_obs[i] = m_alive[i] && !hit_obs[i]
                          && (m_obs_y[i] + `OBS_SIZE - 1 >= `SCREEN_H - 1);
            if (tick && run) begin
                hit  |= hit_obs[i];
                miss |= miss_obs[i];
            end
            any_alive |= m_alive[i];
        end

        case (m_state)
            shooter_pkg::NEWGAME: begin
                if (key[4]) begin
                    m_state = shooter_pkg::PLAY;
                    m_lives = `START_LIVES;
                    m_score = 0;
                end
            end
            shooter_pkg::PLAY: begin
                if (hit) begin
                    m_score = (m_score + 1) % 100;
                    hit_count++;
                end
                if (miss) begin
                    miss_count++;
                    m_lives--;
                    m_state = (m_lives == 0) ? shooter_pkg::OVER : shooter_pkg::NEWGUN;
                    if (m_lives == 0)
                        over_count++;
                end
            end
            shooter_pkg::NEWGUN: if (key[4]) m_state = shooter_pkg::PLAY;
            shooter_pkg::OVER:   if (key[4]) m_state = shooter_pkg::NEWGAME;
        endcase

        if (!run) begin
            spawn_objects();
        end else if (tick) begin
            old_gun_x = m_gun_x;
            if (key == shooter_pkg::KEY_RIGHT && m_gun_x + `GUN_V + `GUN_W <= `SCREEN_W)
                m_gun_x += `GUN_V;
            else if (key == shooter_pkg::KEY_LEFT && m_gun_x - `GUN_V >= 0)
                m_gun_x -= `GUN_V;
            if (hit || key != shooter_pkg::KEY_FIRE || m_shot_y < `SHOT_V) begin
                m_shot_x = old_gun_x + MUZZLE_DX;
                m_shot_y = MUZZLE_Y;
            end else begin
                m_shot_y -= `SHOT_V;
            end
            for (int i = 0; i < `NUM_OBS; i++) begin
                if (!any_alive) begin
                    m_obs_x[i] = `OBS_X0 + i * `OBS_PITCH; // new wave
                    m_obs_y[i] = `OBS_Y0;
                    m_alive[i] = 1'b1;
                end else if (hit_obs[i] || miss_obs[i]) begin
                    m_alive[i] = 1'b0;
                end else if (m_alive[i]) begin
                    m_obs_y[i] += `OBS_V;
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_state = shooter_pkg::NEWGAME;
            m_lives = `START_LIVES;
            m_score = 0;
            exp_rgb = shooter_pkg::BLACK;
            spawn_objects();
        end else begin
            exp_rgb = expected_color(int'(x_i), int'(y_i)); // state before this edge
            advance_model(int'(x_i), int'(y_i), key_i);
        end
    end

    // registered outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_value("rgb_o", exp_rgb, rgb_i);
            check_value("score_o.tens", m_score / 10, score_i.tens);
            check_value("score_o.ones", m_score % 10, score_i.ones);
            check_value("lives_o", m_lives, lives_i);
            check_value("game_over_o", m_state == shooter_pkg::OVER, game_over_i);
        end
    end

endmodule

`default_nettype wire

//--- verification/shooter_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "shooter_config.svh"

module shooter_tb;

    localparam int NUM_FRAMES   = 3000;
    localparam int FRAME_CYCLES = 5;
    localparam int CYCLE_LIMIT  = 2 * NUM_FRAMES * FRAME_CYCLES;
    localparam int GUN_H        = `GUN_Y_B - `GUN_Y_T + 1;

    logic                clk = 1'b0;
    logic                rst;
    shooter_pkg::coord_t x;
    shooter_pkg::coord_t y;
    logic [4:0]          key;
    shooter_pkg::color_e rgb;
    shooter_pkg::score_t score;
    logic [1:0]          lives;
    logic                game_over;
    logic [31:0]         lcg_state = 32'hcf2ed3b1;
    int                  cycle_count = 0;

    always #4 clk = ~clk;

    shooter_top DUT (
        .clk(clk), .rst(rst), .x_i(x), .y_i(y), .key_i(key),
        .rgb_o(rgb), .score_o(score), .lives_o(lives), .game_over_o(game_over)
    );

    shooter_checker u_checker (
        .clk(clk), .rst(rst), .x_i(x), .y_i(y), .key_i(key),
        .rgb_i(rgb), .score_i(score), .lives_i(lives), .game_over_i(game_over)
    );

    bind shooter_top shooter_assertions u_assertions (
        .clk(clk), .rst(rst), .rgb_i(rgb_o), .score_i(score_o),
        .lives_i(lives_o), .game_over_i(game_over_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(input int range, output int value);
        lcg_state = lcg_next(lcg_state);
        value     = int'(lcg_state[31:16]) % range; // upper bits are the better ones
    endtask

    // fire held in bursts, gun drifts one way for 350 frames, then the other
    task automatic pick_key(input int frame, output logic [4:0] k);
        int  r;
        bit  go_right;
        draw(16, r);
        go_right = ((frame / 350) % 2) == 0;
        if (frame < 20 || ((frame % 1000) >= 700 && (frame % 1000) < 950))
            k = 5'h00; // idle stretch, obstacles reach the floor
        else if ((frame % 64) < 12 || r < 4)
            k = shooter_pkg::KEY_FIRE;
        else if (r < 14)
            k = go_right ? shooter_pkg::KEY_RIGHT : shooter_pkg::KEY_LEFT;
        else if (r == 14)
            k = go_right ? shooter_pkg::KEY_LEFT : shooter_pkg::KEY_RIGHT;
        else
            k = 5'h00;
    endtask

    // mostly near a sprite of the model, sometimes anywhere
    task automatic pick_probe(output int px, output int py);
        int sel;
        int idx;
        int dx;
        int dy;
        draw(8, sel);
        draw(`NUM_OBS, idx);
        draw(`GUN_W + 8, dx);
        draw(GUN_H + 8, dy);
        case (sel)
            0, 1: begin
                draw(`SCREEN_W, px);
                draw(`SCREEN_H, py);
            end
            2: begin
                px = u_checker.m_gun_x - 4 + dx;
                py = `GUN_Y_T - 4 + dy;
            end
            3: begin
                px = u_checker.m_shot_x - 4 + dx % (`SHOT_SIZE + 8);
                py = u_checker.m_shot_y - 4 + dy % (`SHOT_SIZE + 8);
            end
            default: begin
                px = u_checker.m_obs_x[idx] - 4 + dx % (`OBS_SIZE + 8);
                py = u_checker.m_obs_y[idx] - 4 + dy % (`OBS_SIZE + 8);
            end
        endcase
        px = (px < 0) ? 0 : ((px > `SCREEN_W - 1) ? `SCREEN_W - 1 : px);
        py = (py < 0) ? 0 : ((py > `SCREEN_H - 1) ? `SCREEN_H - 1 : py);
        if (px == `SCREEN_W - 1 && py == `SCREEN_H - 1)
            px = `SCREEN_W - 2; // keep the tick pixel for the frame end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int         px;
        int         py;
        int         errors;
        logic [4:0] k;
        rst = 1'b1;
        x   = '0;
        y   = '0;
        key = 5'h00;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int frame = 0; frame < NUM_FRAMES; frame++) begin
            pick_key(frame, k);
            for (int p = 0; p < FRAME_CYCLES - 1; p++) begin
                @(negedge clk);
                pick_probe(px, py);
                key = k;
                x   = shooter_pkg::coord_t'(px);
                y   = shooter_pkg::coord_t'(py);
            end
            @(negedge clk);
            x = shooter_pkg::coord_t'(`SCREEN_W - 1); // frame tick
            y = shooter_pkg::coord_t'(`SCREEN_H - 1);
        end
        @(negedge clk);
        x   = '0;
        y   = '0;
        key = 5'h00;
        repeat (2) @(negedge clk);
        errors = u_checker.error_count + DUT.u_assertions.fail_count;
        $display("errors: %0d mismatches, %0d assertion failures (%0d hits, %0d misses, %0d overs)",
                 u_checker.error_count, DUT.u_assertions.fail_count,
                 u_checker.hit_count, u_checker.miss_count, u_checker.over_count);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
